//--- common/opll_pkg.sv
// --------------------
// shared constants and types for the FM-style sound block
// register map, wave select, divider and mixer sizing
// import inside module bodies, scoped names in port lists
// --------------------
`default_nettype none

package opll_pkg;

	// --------------------
	// channel and bus sizing
	localparam int NUM_CH = 3;              // tone channels
	localparam logic [7:0] PORT_BASE = 8'h7C; // 7Ch addr, 7Dh data
	localparam int FNUM_W = 9;              // frequency number
	localparam int BLOCK_W = 3;             // octave shift
	localparam int ATTEN_W = 4;             // attenuation, 6 dB steps

	// --------------------
	// sample timing
	localparam int DIV_RATIO = 12;          // clocks per sample
	localparam int DIV_W = $clog2(DIV_RATIO); // divider counter width
	localparam int PHASE_W = 18;            // phase accumulator

	// --------------------
	// output path
	localparam int CH_OUT_W = 13;           // signed channel level
	localparam int MASTER_GAIN = 10;        // fixed melody volume
	localparam int SAMPLE_W = 16;           // final pcm width
	localparam int MIX_W = 20;              // sum and gain headroom
	localparam int SAT_MAX = 2 ** (SAMPLE_W - 1) - 1;
	localparam int SAT_MIN = -(2 ** (SAMPLE_W - 1));

	// register group, high nibble of the latched address
	typedef enum logic [3:0] {
		GRP_FNUM_LO = 4'h1,                 // fnum[7:0]
		GRP_CTRL    = 4'h2,                 // wave, key, block, fnum[8]
		GRP_ATTEN   = 4'h3                  // attenuation in [3:0]
	} reg_group_e;

	typedef enum logic {
		WAVE_SQUARE = 1'b0,
		WAVE_SAW    = 1'b1
	} wave_e;

endpackage

`default_nettype wire

//--- opll_core/opll_regs.sv
// --------------------
// bus register file for the tone channels
// write to A0=0 latches the register address,
// write to A0=1 stores data into that register
// --------------------
`timescale 1ns/1ps
`default_nettype none

module opll_regs (
	input  wire logic                                                  clk,
	input  wire logic                                                  reset_n,
	input  wire logic                                                  i_cs_n,
	input  wire logic                                                  i_wr_n,
	input  wire logic                                                  i_a0,
	input  wire logic [7:0]                                            i_wdata,
	output      logic [opll_pkg::NUM_CH-1:0][opll_pkg::FNUM_W-1:0]     o_fnum,
	output      logic [opll_pkg::NUM_CH-1:0][opll_pkg::BLOCK_W-1:0]    o_block,
	output      logic [opll_pkg::NUM_CH-1:0]                           o_key,
	output      opll_pkg::wave_e [opll_pkg::NUM_CH-1:0]                o_wave,
	output      logic [opll_pkg::NUM_CH-1:0][opll_pkg::ATTEN_W-1:0]    o_atten
);
	import opll_pkg::*;

	logic       wr_act;     // cs and wr both low
	logic       wr_d;       // previous strobe state
	logic       wr_pulse;   // first clock of a strobe
	logic [7:0] reg_addr;   // latched register address
	reg_group_e grp;        // high nibble
	logic [3:0] ch_sel;     // low nibble

	// --------------------
	// strobe edge detect, a held strobe writes once
	assign wr_act   = ~i_cs_n & ~i_wr_n;
	assign wr_pulse = wr_act & ~wr_d;

	assign grp    = reg_group_e'(reg_addr[7:4]);
	assign ch_sel = reg_addr[3:0];

	// --------------------
	// address latch and field storage
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			wr_d     <= 1'b0;
			reg_addr <= '0;
			for (int i = 0; i < NUM_CH; i++) begin
				o_fnum[i]  <= '0;
				o_block[i] <= '0;
				o_key[i]   <= 1'b0;           // all keys off
				o_wave[i]  <= WAVE_SQUARE;
				o_atten[i] <= '0;
			end
		end else begin
			wr_d <= wr_act;
			if (wr_pulse && !i_a0) begin
				reg_addr <= i_wdata;          // address phase
			end
			if (wr_pulse && i_a0) begin
				// channels >= NUM_CH never match, so they drop out here
				for (int i = 0; i < NUM_CH; i++) begin
					if (ch_sel == 4'(i)) begin
						case (grp)
							GRP_FNUM_LO: o_fnum[i][FNUM_W-2:0] <= i_wdata;
							GRP_CTRL: begin
								o_fnum[i][FNUM_W-1] <= i_wdata[0];   // fnum msb
								o_block[i]          <= i_wdata[BLOCK_W:1];
								o_key[i]            <= i_wdata[4];
								o_wave[i]           <= wave_e'(i_wdata[5]);
							end
							GRP_ATTEN: o_atten[i] <= i_wdata[ATTEN_W-1:0];
							default: ;                // unknown group, ignored
						endcase
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- opll_core/opll_channel.sv
// --------------------
// one tone channel, phase accumulator oscillator
// square or sawtooth, attenuated by an arithmetic shift
// advances once per sample enable
// --------------------
`timescale 1ns/1ps
`default_nettype none

module opll_channel (
	input  wire logic                                 clk,
	input  wire logic                                 reset_n,
	input  wire logic                                 i_sample_en,
	input  wire logic [opll_pkg::FNUM_W-1:0]          i_fnum,
	input  wire logic [opll_pkg::BLOCK_W-1:0]         i_block,
	input  wire logic                                 i_key,
	input  wire opll_pkg::wave_e                      i_wave,
	input  wire logic [opll_pkg::ATTEN_W-1:0]         i_atten,
	output      logic signed [opll_pkg::CH_OUT_W-1:0] o_level
);
	import opll_pkg::*;

	logic [PHASE_W-1:0]         phase;    // wraps mod 2^18
	logic [PHASE_W-1:0]         step;     // fnum << block
	logic signed [CH_OUT_W-1:0] raw;      // full scale wave
	logic signed [CH_OUT_W-1:0] shaped;   // after attenuation

	// --------------------
	// phase increment
	// fnum is 9 bits and block at most 7, so the step fits 16 bits
	assign step = {{(PHASE_W - FNUM_W){1'b0}}, i_fnum} << i_block;

	// --------------------
	// wave shaping from the current phase
	always_comb begin
		if (i_wave == WAVE_SQUARE) begin
			if (phase[PHASE_W-1]) begin
				raw = -13'sd2048;                 // second half
			end else begin
				raw = 13'sd2047;                  // first half
			end
		end else begin
			// top 12 phase bits as signed, sign extended
			raw = {phase[PHASE_W-1], phase[PHASE_W-1 -: CH_OUT_W-1]};
		end
	end

	assign shaped = raw >>> i_atten;          // keeps the sign

	// --------------------
	// accumulator and output register
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			phase   <= '0;
			o_level <= '0;
		end else if (i_sample_en) begin
			if (i_key) begin
				phase   <= phase + step;          // natural wrap
				o_level <= shaped;
			end else begin
				phase   <= '0;                    // restart on next key-on
				o_level <= '0;                    // silent
			end
		end
	end

endmodule

`default_nettype wire

//--- opll_core/opll_mixer.sv
// --------------------
// channel mixer with fixed master gain
// sums levels the clock after the sample enable,
// saturates to the signed 16-bit output range
// --------------------
`timescale 1ns/1ps
`default_nettype none

module opll_mixer (
	input  wire logic                                                  clk,
	input  wire logic                                                  reset_n,
	input  wire logic                                                  i_sample_en,
	input  wire logic [opll_pkg::NUM_CH-1:0][opll_pkg::CH_OUT_W-1:0]   i_levels,
	output      logic signed [opll_pkg::SAMPLE_W-1:0]                  o_sound_out
);
	import opll_pkg::*;

	logic                       en_d;     // enable delayed one clock
	logic signed [MIX_W-1:0]    sum;      // plain sum of channels
	logic signed [MIX_W-1:0]    gained;   // sum times gain
	logic signed [SAMPLE_W-1:0] sat;      // clipped result

	// --------------------
	// sum and gain
	always_comb begin
		logic signed [CH_OUT_W-1:0] lvl;
		sum = '0;
		for (int i = 0; i < NUM_CH; i++) begin
			lvl = i_levels[i];
			sum = sum + {{(MIX_W - CH_OUT_W){lvl[CH_OUT_W-1]}}, lvl}; // sign extend
		end
		gained = sum * MIX_W'(MASTER_GAIN);
	end

	// --------------------
	// saturation
	always_comb begin
		if (gained > MIX_W'(SAT_MAX)) begin
			sat = SAMPLE_W'(SAT_MAX);             // +32767
		end else if (gained < MIX_W'(SAT_MIN)) begin
			sat = SAMPLE_W'(SAT_MIN);             // -32768
		end else begin
			sat = gained[SAMPLE_W-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			en_d        <= 1'b0;
			o_sound_out <= '0;
		end else begin
			en_d <= i_sample_en;
			if (en_d) begin
				o_sound_out <= sat;                // holds for a full sample
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/ip_opll.sv
// --------------------
// sound block top level on the 8-bit i/o bus
// decodes ports 7Ch/7Dh, makes the sample enable,
// runs three tone channels and mixes them to one pcm sample
// --------------------
`timescale 1ns/1ps
`default_nettype none

module ip_opll (
	input  wire logic                                 clk,
	input  wire logic                                 reset_n,
	input  wire logic                                 i_iorq_n,
	input  wire logic                                 i_wr_n,
	input  wire logic [15:0]                          i_address,
	input  wire logic [7:0]                           i_wdata,
	output      logic signed [opll_pkg::SAMPLE_W-1:0] o_sound_out
);
	import opll_pkg::*;

	logic                                cs_n;       // port select, low active
	logic [DIV_W-1:0]                    div_cnt;    // 0..11
	logic                                sample_en;  // one clock in twelve
	logic [NUM_CH-1:0][FNUM_W-1:0]       fnum;
	logic [NUM_CH-1:0][BLOCK_W-1:0]      block;
	logic [NUM_CH-1:0]                   key;
	wave_e [NUM_CH-1:0]                  wave;
	logic [NUM_CH-1:0][ATTEN_W-1:0]      atten;
	logic [NUM_CH-1:0][CH_OUT_W-1:0]     levels;     // channel outputs to mixer

	// --------------------
	// port decode, high byte ignored
	assign cs_n = ~(~i_iorq_n & (i_address[7:1] == PORT_BASE[7:1]));

	// --------------------
	// sample divider
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			div_cnt <= '0;
		end else if (div_cnt == DIV_W'(DIV_RATIO - 1)) begin
			div_cnt <= '0;                      // wrap
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	assign sample_en = (div_cnt == DIV_W'(DIV_RATIO - 1)); // first at 12 clocks

	opll_regs u_regs (
		.clk     (clk),
		.reset_n (reset_n),
		.i_cs_n  (cs_n),
		.i_wr_n  (i_wr_n),
		.i_a0    (i_address[0]),        // 0 addr, 1 data
		.i_wdata (i_wdata),
		.o_fnum  (fnum),
		.o_block (block),
		.o_key   (key),
		.o_wave  (wave),
		.o_atten (atten)
	);

	// --------------------
	// tone channels
	for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
		opll_channel u_channel (
			.clk         (clk),
			.reset_n     (reset_n),
			.i_sample_en (sample_en),
			.i_fnum      (fnum[i]),
			.i_block     (block[i]),
			.i_key       (key[i]),
			.i_wave      (wave[i]),
			.i_atten     (atten[i]),
			.o_level     (levels[i])
		);
	end

	opll_mixer u_mixer (
		.clk         (clk),
		.reset_n     (reset_n),
		.i_sample_en (sample_en),
		.i_levels    (levels),
		.o_sound_out (o_sound_out)
	);

endmodule

`default_nettype wire

//--- bench/ip_opll_properties.sv
// --------------------
// concurrent checks bound into the sound block top level
// sample enable period, output update timing, output in reset
// --------------------
`timescale 1ns/1ps
`default_nettype none

module ip_opll_properties (
	input wire logic                                 clk,
	input wire logic                                 reset_n,
	input wire logic                                 i_sample_en,
	input wire logic signed [opll_pkg::SAMPLE_W-1:0] i_sound_out
);
	import opll_pkg::*;

	int unsigned fail_count = 0;    // read by the testbench at the end
	int          since_en;          // clocks since the last enable

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			since_en <= 0;
		end else if (i_sample_en) begin
			since_en <= 0;
		end else begin
			since_en <= since_en + 1;
		end
	end

	// one enable in twelve, counted from reset release
	a_enable_period: assert property (@(posedge clk) disable iff (!reset_n)
		i_sample_en == (since_en == DIV_RATIO - 1))
	else begin
		fail_count++;
		$error("sample enable outside its twelve clock period");
	end

	// mixer output moves only two clocks after an enable
	a_output_timing: assert property (@(posedge clk) disable iff (!reset_n)
		(i_sound_out != $past(i_sound_out)) |-> $past(i_sample_en, 2))
	else begin
		fail_count++;
		$error("o_sound_out changed away from its update slot");
	end

	a_reset_quiet: assert property (@(posedge clk) !reset_n |=> (i_sound_out == '0))
	else begin
		fail_count++;
		$error("o_sound_out not zero in reset");
	end

endmodule

bind ip_opll ip_opll_properties u_props (
	.clk         (clk),
	.reset_n     (reset_n),
	.i_sample_en (sample_en),
	.i_sound_out (o_sound_out)
);

`default_nettype wire

//--- bench/tb_ip_opll.sv
// --------------------
// testbench for the sound block top level
// lcg driven bus writes, cycle model of divider, channels and mixer,
// o_sound_out compared against the model on every falling edge
// --------------------
`timescale 1ns/1ps
`default_nettype none

module tb_ip_opll;
	import opll_pkg::*;

	localparam int CLK_HALF = 2;            // 4 ns period
	localparam int RESET_CYCLES = 16;
	localparam int MAX_HOLD = 4;            // strobe clocks per write
	localparam int MAX_GAP = 5;             // idle clocks after a write
	localparam int WRITE_CLKS = MAX_HOLD + MAX_GAP + 1;
	localparam int PLANNED_WRITES = 100;
	localparam int PLANNED_SAMPLES = 2100;  // all sample waits together
	localparam int SAT_WAIT = 1500;         // samples allowed to reach both rails
	localparam int WATCHDOG_CLKS = PLANNED_WRITES * WRITE_CLKS
		+ PLANNED_SAMPLES * DIV_RATIO + 2000;

	logic                       clk;
	logic                       reset_n;
	logic                       iorq_n;
	logic                       wr_n;
	logic [15:0]                address;
	logic [7:0]                 wdata;
	logic signed [SAMPLE_W-1:0] sound_out;

	int unsigned rng_state;                 // lcg state

	// --------------------
	// reference model state
	int m_fnum  [NUM_CH];
	int m_block [NUM_CH];
	int m_key   [NUM_CH];
	int m_wave  [NUM_CH];
	int m_atten [NUM_CH];
	int m_phase [NUM_CH];
	int m_level [NUM_CH];                   // channel stage
	int m_addr;                             // latched register address
	int m_cnt;                              // divider 0..11
	int m_out;                              // mixer stage
	bit m_wr_d;
	bit m_en_d;

	ip_opll UUT (
		.clk         (clk),
		.reset_n     (reset_n),
		.i_iorq_n    (iorq_n),
		.i_wr_n      (wr_n),
		.i_address   (address),
		.i_wdata     (wdata),
		.o_sound_out (sound_out)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_HALF) clk = ~clk;
	end

	function automatic int unsigned lcg_next();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state >> 16;                 // upper bits have a longer period
	endfunction

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'(lcg_next() % 32'(hi - lo + 1));
	endfunction

	// full scale wave from the phase and then the attenuation shift
	function automatic int wave_level(input int phase, input int wave, input int atten);
		int raw;
		if (wave == 0) begin
			raw = (((phase >> (PHASE_W - 1)) & 1) != 0) ? -2048 : 2047;
		end else begin
			raw = (phase >> (PHASE_W - 12)) & 32'hFFF;  // top 12 bits
			if (raw >= 2048) begin
				raw = raw - 4096;                        // as signed
			end
		end
		return raw >>> atten;
	endfunction

	function automatic int clamp16(input int value);
		if (value > 32767) begin
			return 32767;
		end else if (value < -32768) begin
			return -32768;
		end
		return value;
	endfunction

	function automatic logic [7:0] ctrl_byte(input logic [8:0] fnum, input logic [2:0] block,
			input bit key, input wave_e wave);
		return {2'b00, wave, key, block, fnum[8]};
	endfunction

	// --------------------
	// model step, one call per rising edge
	always @(posedge clk) begin : model_step
		int sum;
		int ch;
		bit wr_act;
		bit wr_pulse;
		bit en;
		if (!reset_n) begin
			for (int i = 0; i < NUM_CH; i++) begin
				m_fnum[i]  = 0;
				m_block[i] = 0;
				m_key[i]   = 0;
				m_wave[i]  = 0;
				m_atten[i] = 0;
				m_phase[i] = 0;
				m_level[i] = 0;
			end
			m_addr = 0;
			m_cnt  = 0;
			m_out  = 0;
			m_wr_d = 1'b0;
			m_en_d = 1'b0;
		end else begin
			wr_act   = !iorq_n && !wr_n && (address[7:1] == PORT_BASE[7:1]);
			wr_pulse = wr_act && !m_wr_d;
			en       = (m_cnt == DIV_RATIO - 1);
			if (m_en_d) begin                     // mixer reads the old levels
				sum = 0;
				for (int i = 0; i < NUM_CH; i++) begin
					sum = sum + m_level[i];
				end
				m_out = clamp16(sum * MASTER_GAIN);
			end
			m_en_d = en;
			if (en) begin
				for (int i = 0; i < NUM_CH; i++) begin
					if (m_key[i] != 0) begin
						m_level[i] = wave_level(m_phase[i], m_wave[i], m_atten[i]);
						m_phase[i] = (m_phase[i] + (m_fnum[i] << m_block[i])) & (2 ** PHASE_W - 1);
					end else begin
						m_level[i] = 0;
						m_phase[i] = 0;
					end
				end
			end
			if (wr_pulse && !address[0]) begin
				m_addr = int'(wdata);
			end else if (wr_pulse) begin
				ch = m_addr & 15;
				if (ch < NUM_CH) begin
					case (m_addr >> 4)
						int'(GRP_FNUM_LO): m_fnum[ch] = (m_fnum[ch] & 32'h100) | int'(wdata);
						int'(GRP_CTRL): begin
							m_fnum[ch]  = (m_fnum[ch] & 32'hFF) | (int'(wdata[0]) << 8);
							m_block[ch] = int'(wdata[3:1]);
							m_key[ch]   = int'(wdata[4]);
							m_wave[ch]  = int'(wdata[5]);
						end
						int'(GRP_ATTEN): m_atten[ch] = int'(wdata[3:0]);
						default: ;
					endcase
				end
			end
			m_wr_d = wr_act;
			m_cnt  = en ? 0 : m_cnt + 1;
		end
	end

	task automatic report_mismatch(input string what, input int got, input int expected);
		$display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
		$display("TB FAILED");
		$fatal(1, "stopped at the first mismatch");
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1, "stopped on a failed check");
	endtask

	always @(negedge clk) begin
		assert (sound_out === 16'(m_out))
		else report_mismatch("o_sound_out", int'(sound_out), m_out);
	end

	// --------------------
	// bus stimulus
	task automatic bus_write(input logic [15:0] addr, input logic [7:0] data,
			input int hold, input int gap);
		@(negedge clk);
		iorq_n  = 1'b0;
		wr_n    = 1'b0;
		address = addr;
		wdata   = data;
		@(negedge clk);
		wdata = ~data;                          // later strobe clocks carry other data
		repeat (hold - 1) @(negedge clk);
		iorq_n = 1'b1;
		wr_n   = 1'b1;
		repeat (gap) @(negedge clk);
	endtask

	// address then data with a random high byte each time
	task automatic reg_write_hold(input logic [7:0] reg_addr, input logic [7:0] value,
			input int hold);
		bus_write({8'(lcg_next()), PORT_BASE}, reg_addr, hold, rand_range(0, MAX_GAP));
		bus_write({8'(lcg_next()), PORT_BASE | 8'h01}, value, hold, rand_range(0, MAX_GAP));
	endtask

	task automatic reg_write(input logic [7:0] reg_addr, input logic [7:0] value);
		reg_write_hold(reg_addr, value, rand_range(1, MAX_HOLD));
	endtask

	task automatic setup_channel(input int ch, input int hold, input logic [8:0] fnum,
			input logic [2:0] block, input wave_e wave, input logic [3:0] atten);
		reg_write_hold({GRP_FNUM_LO, 4'(ch)}, fnum[7:0], hold);
		reg_write({GRP_ATTEN, 4'(ch)}, {4'h0, atten});
		reg_write({GRP_CTRL, 4'(ch)}, ctrl_byte(fnum, block, 1'b1, wave));  // key on last
	endtask

	task automatic key_off(input int ch);
		reg_write({GRP_CTRL, 4'(ch)}, 8'h00);
	endtask

	task automatic wait_samples(input int n);
		repeat (n * DIV_RATIO) @(negedge clk);
	endtask

	// first nonzero sample and then one value per sample period
	task automatic capture_tone(output int tone [8]);
		while (sound_out == 16'sd0) @(negedge clk);
		for (int k = 0; k < 8; k++) begin
			tone[k] = int'(sound_out);
			repeat (DIV_RATIO) @(negedge clk);
		end
	endtask

	initial begin : stimulus
		int         tone_a [8];
		int         tone_b [8];
		int         flips;
		int         hi_hits;
		int         lo_hits;
		bit         prev_sign;
		logic [7:0] port;
		logic [8:0] fnum;
		logic [2:0] block;
		logic [3:0] atten;

		rng_state = 38545;
		iorq_n    = 1'b1;
		wr_n      = 1'b1;
		address   = '0;
		wdata     = '0;
		reset_n   = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk);
		reset_n = 1'b1;

		// --------------------
		// stray ports and unknown groups or channels stay silent
		bus_write({8'h00, PORT_BASE}, {GRP_CTRL, 4'h0}, 1, 0);  // point at channel 0 control
		for (int k = 0; k < 4; k++) begin
			port = 8'(lcg_next()) | 8'h01;            // data side of a wrong port
			if (port[7:1] == PORT_BASE[7:1]) begin
				port = port ^ 8'h80;                  // move off 7Ch/7Dh
			end
			bus_write({8'(lcg_next()), port}, 8'h10,  // key on if it were taken
				rand_range(1, MAX_HOLD), rand_range(0, MAX_GAP));
		end
		reg_write(8'h40, 8'hFF);                  // group 4 unused
		reg_write({GRP_CTRL, 4'h3}, 8'h3F);       // channel 3 absent
		reg_write({GRP_CTRL, 4'hF}, 8'h3F);
		wait_samples(4);
		assert (sound_out == 16'sd0)
		else report_mismatch("output before any key-on", int'(sound_out), 0);

		// --------------------
		// held strobe and single strobe give the same tone
		fnum  = 9'(rand_range(64, 511));
		block = 3'(rand_range(3, 7));
		atten = 4'(rand_range(0, 3));
		setup_channel(0, MAX_HOLD, fnum, block, WAVE_SAW, atten);
		capture_tone(tone_a);
		key_off(0);
		wait_samples(3);
		setup_channel(0, 1, fnum, block, WAVE_SAW, atten);
		capture_tone(tone_b);
		for (int k = 0; k < 8; k++) begin
			assert (tone_b[k] == tone_a[k])
			else report_mismatch("single strobe tone sample", tone_b[k], tone_a[k]);
		end
		key_off(0);
		wait_samples(3);

		// --------------------
		// square on channel 0 must change sign
		setup_channel(0, rand_range(1, MAX_HOLD), 9'(rand_range(64, 511)),
			3'(rand_range(4, 7)), WAVE_SQUARE, 4'(rand_range(0, 11)));
		flips     = 0;
		prev_sign = sound_out[15];
		repeat (200 * DIV_RATIO) begin
			@(negedge clk);
			if (sound_out[15] != prev_sign) begin
				flips++;
			end
			prev_sign = sound_out[15];
		end
		assert (flips > 0)
		else abort_run("square wave on channel 0 never changed sign");
		key_off(0);

		// sawtooth with attenuation on channel 1
		setup_channel(1, rand_range(1, MAX_HOLD), 9'(rand_range(1, 511)),
			3'(rand_range(0, 7)), WAVE_SAW, 4'(rand_range(0, 15)));
		wait_samples(150);
		key_off(1);

		// --------------------
		// three squares at full level reach both rails
		for (int ch = 0; ch < NUM_CH; ch++) begin
			setup_channel(ch, rand_range(1, MAX_HOLD), 9'(rand_range(128, 511)),
				3'(rand_range(6, 7)), WAVE_SQUARE, 4'h0);
		end
		hi_hits = 0;
		lo_hits = 0;
		for (int n = 0; n < SAT_WAIT * DIV_RATIO && (hi_hits == 0 || lo_hits == 0); n++) begin
			@(negedge clk);
			if (sound_out == 16'sh7FFF) begin
				hi_hits++;
			end
			if (sound_out == 16'sh8000) begin
				lo_hits++;
			end
		end
		assert (hi_hits > 0 && lo_hits > 0)
		else abort_run("mixed channels never reached both saturation limits");

		// --------------------
		// key-off clears phase and output and key-on restarts
		for (int ch = 0; ch < NUM_CH; ch++) begin
			key_off(ch);
		end
		wait_samples(3);
		assert (sound_out == 16'sd0)
		else report_mismatch("output after key-off", int'(sound_out), 0);
		assert (UUT.g_ch[0].u_channel.phase == '0 && UUT.g_ch[1].u_channel.phase == '0
				&& UUT.g_ch[2].u_channel.phase == '0)
		else abort_run("a channel phase kept running after key-off");
		setup_channel(2, rand_range(1, MAX_HOLD), 9'(rand_range(1, 511)),
			3'(rand_range(2, 7)), WAVE_SAW, 4'(rand_range(0, 6)));
		wait_samples(40);

		wait_samples(2);
		if (UUT.u_props.fail_count == 0) begin
			$display("TB PASSED");
			$finish;
		end else begin
			$display("%0d bound property failures", UUT.u_props.fail_count);
			$display("TB FAILED");
			$fatal(1, "bound properties failed");
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG_CLKS) @(posedge clk);
		$display("watchdog expired, the test sequence did not finish in time");
		$display("TB FAILED");
		$fatal(1, "watchdog timeout");
	end

endmodule

`default_nettype wire

//--- ip_opll.f
common/opll_pkg.sv
opll_core/opll_regs.sv
opll_core/opll_channel.sv
opll_core/opll_mixer.sv
hdl/ip_opll.sv
bench/ip_opll_properties.sv
bench/tb_ip_opll.sv

//--- Makefile
# Verilator flow for the ip_opll sound block

VERILATOR ?= verilator
TOP       := tb_ip_opll
FILELIST  := ip_opll.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := TB PASSED
COMMON    := --timing --timescale 1ns/1ps --top-module $(TOP) -f $(FILELIST)
VFLAGS    := --binary --assert -j 0 --Mdir $(OBJ_DIR)
LINTFLAGS := --lint-only

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) $(COMMON)

sim:
	$(VERILATOR) $(VFLAGS) $(COMMON)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
